/* expu_pkg.sv */
package expu_pkg;

    // bfloat16 word layout
    localparam int unsigned WIDTH     = 16;
    localparam int unsigned EXP_BITS  = 8;
    localparam int unsigned MANT_BITS = 7;
    localparam int unsigned EXP_BIAS  = 127;

    // Fixed-point x*log2(e), with FIX_FRAC fraction bits after scaling
    localparam int unsigned FIX_FRAC   = 7;
    localparam int unsigned LOG2E_FRAC = 10;
    localparam int unsigned LOG2E_Q    = 1477;
    localparam int unsigned PROD_BITS  = MANT_BITS + LOG2E_FRAC + 2;
    localparam int unsigned BIAS_FIX   = EXP_BIAS << FIX_FRAC;

    // Shared buffer and arbiter
    localparam int unsigned ADDR_BITS = 4;
    localparam int unsigned DEPTH     = 16;
    localparam int unsigned NUM_REQ   = 3;
    localparam int unsigned REQ_BITS  = $clog2(NUM_REQ);

    // Mantissa correction, quantized to integer coefficients
    localparam int unsigned COEF_FRAC   = 4;
    localparam int unsigned CONST_FRAC  = 7;
    localparam int unsigned MUL_SURPLUS = 1;
    localparam int unsigned ALPHA_Q     = int'(0.24609375 * 2.0 ** COEF_FRAC);
    localparam int unsigned BETA_Q      = int'(0.41015625 * 2.0 ** COEF_FRAC);
    localparam int unsigned GAMMA1_Q    = int'(2.8359375 * 2.0 ** CONST_FRAC);
    localparam int unsigned GAMMA2_Q    = int'(2.16796875 * 2.0 ** CONST_FRAC);

    // Special result patterns
    localparam logic [WIDTH-1:0] CANON_NAN = 16'h7FC0;
    localparam logic [WIDTH-1:0] POS_INF   = 16'h7F80;
    localparam logic [WIDTH-1:0] ONE       = 16'h3F80;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_RUN} host_op_e;

    typedef enum logic [2:0] {L_IDLE, L_FETCH, L_WAIT, L_CALC, L_STORE, L_NEXT} lane_state_e;

    typedef enum logic [1:0] {H_IDLE, H_ACCESS, H_RUN, H_ACK} host_state_e;

endpackage

/* expu_schraudolph.sv */
`timescale 1ns/1ps

module expu_schraudolph (
    input  logic [expu_pkg::WIDTH-1:0] op,
    output logic [expu_pkg::WIDTH-1:0] res,
    output logic                       normal
);
    import expu_pkg::*;

    logic                 sign;
    logic [EXP_BITS-1:0]  exponent;
    logic [MANT_BITS-1:0] mantissa;
    logic [MANT_BITS:0]   significand;
    logic [EXP_BITS-1:0]  shift;
    logic [PROD_BITS-1:0] product;
    logic [PROD_BITS-1:0] scaled;
    logic [PROD_BITS-1:0] biased;
    logic                 is_nan;
    logic                 is_large;
    logic                 out_of_range;

    assign sign     = op[WIDTH-1];
    assign exponent = op[WIDTH-2 -: EXP_BITS];
    assign mantissa = op[MANT_BITS-1:0];

    // Subnormal inputs lose the hidden bit and act as zero
    assign significand = {exponent != '0, mantissa};
    assign product     = significand * LOG2E_Q[LOG2E_FRAC:0];

    // Align the product to FIX_FRAC fraction bits, truncating
    assign shift  = EXP_BITS'(EXP_BIAS + MANT_BITS + LOG2E_FRAC - FIX_FRAC) - exponent;
    assign scaled = product >> shift;

    always_comb begin
        is_nan = (exponent == '1) && (mantissa != '0);
        // |x| >= 128 saturates whatever the mantissa
        is_large = exponent >= EXP_BITS'(EXP_BIAS + FIX_FRAC);
        if (sign) begin
            biased       = PROD_BITS'(BIAS_FIX) - scaled;
            out_of_range = is_large ||
                           (scaled > PROD_BITS'(BIAS_FIX - (1 << FIX_FRAC)));
        end else begin
            biased       = PROD_BITS'(BIAS_FIX) + scaled;
            out_of_range = is_large ||
                           (biased >= PROD_BITS'(((1 << EXP_BITS) - 1) << FIX_FRAC));
        end
    end

    always_comb begin
        normal = 1'b0;
        if (is_nan) begin
            res = CANON_NAN;
        end else if (out_of_range) begin
            // Too negative flushes to zero, too positive is infinity
            res = sign ? '0 : POS_INF;
        end else begin
            res    = {1'b0, biased[FIX_FRAC +: EXP_BITS], biased[FIX_FRAC-1 -: MANT_BITS]};
            normal = 1'b1;
        end
    end

endmodule

/* expu_correction.sv */
`timescale 1ns/1ps

module expu_correction (
    input  logic [expu_pkg::WIDTH-1:0] op,
    output logic [expu_pkg::WIDTH-1:0] res
);
    import expu_pkg::*;

    logic [EXP_BITS-1:0]  exponent;
    logic [MANT_BITS-1:0] fraction;
    logic                 upper;

    // Fraction operand of the coefficient product, one surplus bit
    logic [MANT_BITS+MUL_SURPLUS-2:0] frac_term;
    logic [COEF_FRAC-2:0]             coef;
    logic [MANT_BITS+COEF_FRAC+MUL_SURPLUS-3:0] coef_prod;

    // Fraction plus gamma, both at CONST_FRAC fraction bits
    logic [CONST_FRAC+1:0] offset_sum;
    logic [MANT_BITS+CONST_FRAC+COEF_FRAC+MUL_SURPLUS-1:0] full_prod;
    logic [MANT_BITS-1:0] fit;

    assign exponent = op[WIDTH-2 -: EXP_BITS];
    assign fraction = op[MANT_BITS-1:0];
    assign upper    = fraction[MANT_BITS-1];

    // Upper half works on the mirrored fraction
    assign frac_term = upper ? ~{fraction[MANT_BITS-2:0], {MUL_SURPLUS{1'b0}}}
                             :  {fraction[MANT_BITS-2:0], {MUL_SURPLUS{1'b0}}};
    assign coef      = upper ? BETA_Q[COEF_FRAC-2:0] : ALPHA_Q[COEF_FRAC-2:0];
    assign coef_prod = frac_term * coef;

    assign offset_sum = {2'b00, fraction} +
                        (upper ? GAMMA2_Q[CONST_FRAC+1:0] : GAMMA1_Q[CONST_FRAC+1:0]);

    assign full_prod = coef_prod * offset_sum;

    // Keep the top MANT_BITS of the product
    assign fit = full_prod[MANT_BITS+CONST_FRAC+COEF_FRAC+MUL_SURPLUS-1 -: MANT_BITS];

    assign res = {1'b0, exponent, upper ? ~fit : fit};

endmodule

/* expu_lane.sv */
`timescale 1ns/1ps

module expu_lane (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic [expu_pkg::ADDR_BITS:0]   count,
    input  logic                           first_addr,
    output logic                           buf_req,
    output logic                           buf_we,
    output logic [expu_pkg::ADDR_BITS-1:0] buf_addr,
    output logic [expu_pkg::WIDTH-1:0]     buf_wdata,
    input  logic                           buf_gnt,
    input  logic [expu_pkg::WIDTH-1:0]     buf_rdata,
    output logic                           done
);
    import expu_pkg::*;

    lane_state_e        state;
    logic [ADDR_BITS:0] idx;
    logic [ADDR_BITS:0] idx_first;
    logic [ADDR_BITS:0] idx_next;
    logic [WIDTH-1:0]   operand;
    logic [WIDTH-1:0]   result;
    logic [WIDTH-1:0]   approx;
    logic [WIDTH-1:0]   corrected;
    logic               approx_normal;

    expu_schraudolph u_schraudolph (
        .op     (operand),
        .res    (approx),
        .normal (approx_normal)
    );

    expu_correction u_correction (
        .op  (approx),
        .res (corrected)
    );

    assign idx_first = {{ADDR_BITS{1'b0}}, first_addr};
    // Lanes interleave, so each one strides by two
    assign idx_next  = idx + (ADDR_BITS+1)'(2);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= L_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (start) begin
                        idx  <= idx_first;
                        done <= !(idx_first < count);
                        if (idx_first < count) begin
                            state <= L_FETCH;
                        end
                    end
                end
                L_FETCH: if (buf_gnt) state <= L_WAIT;
                L_WAIT:  state <= L_CALC;
                L_CALC:  state <= L_STORE;
                L_STORE: if (buf_gnt) state <= L_NEXT;
                L_NEXT: begin
                    idx <= idx_next;
                    if (idx_next < count) begin
                        state <= L_FETCH;
                    end else begin
                        done  <= 1'b1;
                        state <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Operand captured while buffer rdata is still ours
    always_ff @(posedge clk) begin
        if (state == L_WAIT) operand <= buf_rdata;
        if (state == L_CALC) result <= approx_normal ? corrected : approx;
    end

    assign buf_req   = (state == L_FETCH) || (state == L_STORE);
    assign buf_we    = (state == L_STORE);
    assign buf_addr  = idx[ADDR_BITS-1:0];
    assign buf_wdata = result;

endmodule

/* expu_shared_buffer.sv */
`timescale 1ns/1ps

module expu_shared_buffer (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [expu_pkg::NUM_REQ-1:0]                            req,
    input  logic [expu_pkg::NUM_REQ-1:0]                            we,
    input  logic [expu_pkg::NUM_REQ-1:0][expu_pkg::ADDR_BITS-1:0]   addr,
    input  logic [expu_pkg::NUM_REQ-1:0][expu_pkg::WIDTH-1:0]       wdata,
    output logic [expu_pkg::NUM_REQ-1:0]                            gnt,
    output logic [expu_pkg::WIDTH-1:0]                              rdata
);
    import expu_pkg::*;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [REQ_BITS-1:0] ptr;
    logic [REQ_BITS-1:0] sel;
    logic                any;

    // Search starts at ptr and wraps around the requesters
    always_comb begin
        int unsigned cand;
        gnt = '0;
        sel = ptr;
        any = 1'b0;
        for (int k = 0; k < NUM_REQ; k++) begin
            cand = ptr + k;
            if (cand >= NUM_REQ) cand = cand - NUM_REQ;
            if (!any && req[cand]) begin
                any = 1'b1;
                sel = REQ_BITS'(cand);
            end
        end
        if (any) gnt[sel] = 1'b1;
    end

    // Winner drops to lowest priority next time
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (any) begin
            ptr <= (sel == REQ_BITS'(NUM_REQ - 1)) ? '0 : sel + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (any) begin
            if (we[sel]) begin
                mem[addr[sel]] <= wdata[sel];
            end else begin
                rdata <= mem[addr[sel]];
            end
        end
    end

endmodule

/* expu_host_port.sv */
`timescale 1ns/1ps

module expu_host_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  expu_pkg::host_op_e             op,
    input  logic [expu_pkg::ADDR_BITS-1:0] addr,
    input  logic [expu_pkg::WIDTH-1:0]     wdata,
    output logic                           ack,
    output logic [expu_pkg::WIDTH-1:0]     rdata,
    output logic                           buf_req,
    output logic                           buf_we,
    output logic [expu_pkg::ADDR_BITS-1:0] buf_addr,
    output logic [expu_pkg::WIDTH-1:0]     buf_wdata,
    input  logic                           buf_gnt,
    input  logic [expu_pkg::WIDTH-1:0]     buf_rdata,
    output logic                           lane_start,
    output logic [expu_pkg::ADDR_BITS:0]   lane_count,
    input  logic [1:0]                     lane_done
);
    import expu_pkg::*;

    host_state_e state;
    // Read granted, buffer data arrives next cycle
    logic        rd_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= H_IDLE;
            ack        <= 1'b0;
            lane_start <= 1'b0;
            rd_pend    <= 1'b0;
        end else begin
            lane_start <= 1'b0;
            case (state)
                H_IDLE: begin
                    if (req) begin
                        if (op == OP_RUN) begin
                            lane_start <= 1'b1;
                            state      <= H_RUN;
                        end else begin
                            state <= H_ACCESS;
                        end
                    end
                end
                H_ACCESS: begin
                    if (rd_pend) begin
                        rd_pend <= 1'b0;
                        ack     <= 1'b1;
                        state   <= H_ACK;
                    end else if (buf_gnt) begin
                        if (op == OP_WRITE) begin
                            ack   <= 1'b1;
                            state <= H_ACK;
                        end else begin
                            rd_pend <= 1'b1;
                        end
                    end
                end
                H_RUN: begin
                    // Done levels are stale while the start pulse is out
                    if (!lane_start && (&lane_done)) begin
                        ack   <= 1'b1;
                        state <= H_ACK;
                    end
                end
                H_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= H_IDLE;
                    end
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    // Element count rides on wdata with the run command
    always_ff @(posedge clk) begin
        if (state == H_IDLE && req && op == OP_RUN) lane_count <= wdata[ADDR_BITS:0];
        if (rd_pend) rdata <= buf_rdata;
    end

    assign buf_req   = (state == H_ACCESS) && !rd_pend;
    assign buf_we    = (op == OP_WRITE);
    assign buf_addr  = addr;
    assign buf_wdata = wdata;

endmodule

/* expu_top.sv */
`timescale 1ns/1ps

module expu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  expu_pkg::host_op_e             op,
    input  logic [expu_pkg::ADDR_BITS-1:0] addr,
    input  logic [expu_pkg::WIDTH-1:0]     wdata,
    output logic                           ack,
    output logic [expu_pkg::WIDTH-1:0]     rdata
);
    import expu_pkg::*;

    // Requester 0 is the host, 1 and 2 are the lanes
    logic [NUM_REQ-1:0]                buf_req;
    logic [NUM_REQ-1:0]                buf_we;
    logic [NUM_REQ-1:0]                buf_gnt;
    logic [NUM_REQ-1:0][ADDR_BITS-1:0] buf_addr;
    logic [NUM_REQ-1:0][WIDTH-1:0]     buf_wdata;
    logic [WIDTH-1:0]                  buf_rdata;
    logic                              lane_start;
    logic [ADDR_BITS:0]                lane_count;
    logic [1:0]                        lane_done;

    expu_host_port u_host_port (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .rdata      (rdata),
        .buf_req    (buf_req[0]),
        .buf_we     (buf_we[0]),
        .buf_addr   (buf_addr[0]),
        .buf_wdata  (buf_wdata[0]),
        .buf_gnt    (buf_gnt[0]),
        .buf_rdata  (buf_rdata),
        .lane_start (lane_start),
        .lane_count (lane_count),
        .lane_done  (lane_done)
    );

    // Even addresses
    expu_lane lane0 (
        .clk        (clk),
        .rst        (rst),
        .start      (lane_start),
        .count      (lane_count),
        .first_addr (1'b0),
        .buf_req    (buf_req[1]),
        .buf_we     (buf_we[1]),
        .buf_addr   (buf_addr[1]),
        .buf_wdata  (buf_wdata[1]),
        .buf_gnt    (buf_gnt[1]),
        .buf_rdata  (buf_rdata),
        .done       (lane_done[0])
    );

    // Odd addresses
    expu_lane lane1 (
        .clk        (clk),
        .rst        (rst),
        .start      (lane_start),
        .count      (lane_count),
        .first_addr (1'b1),
        .buf_req    (buf_req[2]),
        .buf_we     (buf_we[2]),
        .buf_addr   (buf_addr[2]),
        .buf_wdata  (buf_wdata[2]),
        .buf_gnt    (buf_gnt[2]),
        .buf_rdata  (buf_rdata),
        .done       (lane_done[1])
    );

    expu_shared_buffer u_shared_buffer (
        .clk   (clk),
        .rst   (rst),
        .req   (buf_req),
        .we    (buf_we),
        .addr  (buf_addr),
        .wdata (buf_wdata),
        .gnt   (buf_gnt),
        .rdata (buf_rdata)
    );

endmodule

/* tb_expu.sv */
`timescale 1ns/1ps

module tb_expu;
    import expu_pkg::*;

    localparam int CLK_PERIOD = 40;
    // Host commands and lane elements issued over the whole run
    localparam int N_CMDS  = 107;
    localparam int N_ELEMS = 25;

    logic                 clk;
    logic                 rst;
    logic                 req;
    host_op_e             op;
    logic [ADDR_BITS-1:0] addr;
    logic [WIDTH-1:0]     wdata;
    logic                 ack;
    logic [WIDTH-1:0]     rdata;

    integer           seed;
    logic [WIDTH-1:0] stored [DEPTH];
    logic [WIDTH-1:0] operand [DEPTH];
    logic [WIDTH-1:0] special_exp [4];
    logic [WIDTH-1:0] got;
    bit               seen_low;
    bit               seen_high;

    expu_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string what, input int a,
                              input logic [WIDTH-1:0] seen, input logic [WIDTH-1:0] exp);
        assert (seen === exp) else begin
            $display("[FAIL] %0t: %s at address %0d, got %h, expected %h",
                     $time, what, a, seen, exp);
            abort_run();
        end
    endtask

    // Handshake checks
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
                                    $rose(ack) |-> $past(req))
        else begin
            $display("Protocol error: ack rose while req was low");
            abort_run();
        end
    ack_after_release: assert property (@(posedge clk) disable iff (rst)
                                        $fell(ack) |-> !$past(req))
        else begin
            $display("Protocol error: ack fell while req was still high");
            abort_run();
        end
    ack_released: assert property (@(posedge clk) disable iff (rst) $fell(req) |=> !ack)
        else begin
            $display("Protocol error: ack stayed high after req dropped");
            abort_run();
        end
    ack_in_reset: assert property (@(posedge clk) rst |=> !ack)
        else begin
            $display("Protocol error: ack was high during reset");
            abort_run();
        end

    task automatic wait_ack(input logic level);
        do begin
            @(negedge clk);
        end while (ack !== level);
    endtask

    task automatic handshake();
        req = 1'b1;
        wait_ack(1'b1);
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic host_write(input int a, input logic [WIDTH-1:0] d);
        @(negedge clk);
        op    = OP_WRITE;
        addr  = ADDR_BITS'(a);
        wdata = d;
        handshake();
    endtask

    task automatic host_read(input int a, output logic [WIDTH-1:0] d);
        @(negedge clk);
        op   = OP_READ;
        addr = ADDR_BITS'(a);
        handshake();
        d = rdata;
    endtask

    task automatic host_run(input int n);
        @(negedge clk);
        op    = OP_RUN;
        addr  = '0;
        wdata = WIDTH'(n);
        handshake();
    endtask

    function automatic logic [WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[WIDTH-1:0];
    endfunction

    function automatic logic [WIDTH-1:0] random_operand();
        logic [31:0]         r;
        logic [EXP_BITS-1:0] e;
        r = $random(seed);
        // Exponents 121 to 132 keep 2^-6 <= |x| < 2^6
        e = EXP_BITS'(EXP_BIAS - 6 + r[15:8] % 12);
        return {r[31], e, r[MANT_BITS-1:0]};
    endfunction

    // exp(x) = 2^(x*log2e), biased value split into exponent and mantissa
    function automatic logic [WIDTH-1:0] approx_exp(input logic [WIDTH-1:0] x,
                                                    output bit normal);
        int e;
        int s;
        int fixv;
        int bias_fix;
        int biased;
        normal   = 1'b0;
        e        = int'(x[WIDTH-2 -: EXP_BITS]);
        bias_fix = int'(EXP_BIAS << FIX_FRAC);
        if (e == 255 && x[MANT_BITS-1:0] != '0) return CANON_NAN;
        if (e >= int'(EXP_BIAS + FIX_FRAC)) return x[WIDTH-1] ? '0 : POS_INF;
        // Subnormals have no hidden bit
        s    = (e != 0) ? 128 + int'(x[MANT_BITS-1:0]) : int'(x[MANT_BITS-1:0]);
        fixv = int'((s * LOG2E_Q) >> (EXP_BIAS + MANT_BITS + LOG2E_FRAC - FIX_FRAC - e));
        biased = x[WIDTH-1] ? bias_fix - fixv : bias_fix + fixv;
        if (biased < (1 << FIX_FRAC)) return '0;
        if (biased >= (255 << FIX_FRAC)) return POS_INF;
        normal = 1'b1;
        return WIDTH'(biased);
    endfunction

    function automatic logic [WIDTH-1:0] refine(input logic [WIDTH-1:0] a);
        int f;
        int t;
        int c;
        int g;
        int fit;
        bit up;
        f  = int'(a[MANT_BITS-1:0]);
        up = a[MANT_BITS-1];
        t  = (f % 64) << MUL_SURPLUS;
        // Upper half mirrors the fraction
        if (up) t = (1 << (MANT_BITS + MUL_SURPLUS - 1)) - 1 - t;
        c   = up ? int'(BETA_Q) : int'(ALPHA_Q);
        g   = up ? int'(GAMMA2_Q) : int'(GAMMA1_Q);
        fit = ((t * c * (f + g)) >> (CONST_FRAC + COEF_FRAC + MUL_SURPLUS)) % 128;
        if (up) fit = 127 - fit;
        return {1'b0, a[WIDTH-2 -: EXP_BITS], MANT_BITS'(fit)};
    endfunction

    function automatic logic [WIDTH-1:0] model_exp(input logic [WIDTH-1:0] x);
        logic [WIDTH-1:0] a;
        bit               normal;
        a = approx_exp(x, normal);
        return normal ? refine(a) : a;
    endfunction

    initial begin
        int               tries;
        bit               is_normal;
        logic [WIDTH-1:0] a;
        seed  = 83;
        rst   = 1'b1;
        req   = 1'b0;
        op    = OP_WRITE;
        addr  = '0;
        wdata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Plain write and read back
        for (int i = 0; i < DEPTH; i++) begin
            stored[i] = rand_word();
            host_write(i, stored[i]);
        end
        for (int i = 0; i < DEPTH; i++) begin
            host_read(i, got);
            check_word("read back", i, got, stored[i]);
        end

        // Redraw until both correction halves are hit
        tries = 0;
        do begin
            seen_low  = 1'b0;
            seen_high = 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                operand[i] = random_operand();
                a = approx_exp(operand[i], is_normal);
                if (is_normal && a[MANT_BITS-1]) seen_high = 1'b1;
                if (is_normal && !a[MANT_BITS-1]) seen_low = 1'b1;
            end
            tries++;
        end while (!(seen_low && seen_high) && tries < 20);
        for (int i = 0; i < DEPTH; i++) host_write(i, operand[i]);
        host_run(DEPTH);
        for (int i = 0; i < DEPTH; i++) begin
            host_read(i, got);
            check_word("exp result", i, got, model_exp(operand[i]));
        end
        assert (seen_low && seen_high) else begin
            $display("Coverage error: one correction branch was never exercised");
            abort_run();
        end

        // NaN, 100.0, -100.0 and 0.0
        operand[0]     = 16'h7FC1;
        operand[1]     = 16'h42C8;
        operand[2]     = 16'hC2C8;
        operand[3]     = 16'h0000;
        special_exp[0] = CANON_NAN;
        special_exp[1] = POS_INF;
        special_exp[2] = '0;
        special_exp[3] = ONE;
        for (int i = 0; i < 4; i++) host_write(i, operand[i]);
        host_run(4);
        for (int i = 0; i < 4; i++) begin
            host_read(i, got);
            check_word("special value", i, got, special_exp[i]);
        end

        // Odd count leaves the tail untouched
        for (int i = 0; i < DEPTH; i++) begin
            stored[i] = rand_word();
            host_write(i, stored[i]);
        end
        host_run(5);
        for (int i = 0; i < DEPTH; i++) begin
            host_read(i, got);
            check_word("partial run", i, got, (i < 5) ? model_exp(stored[i]) : stored[i]);
        end

        $display("** PASS **");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (8 + 200 * N_CMDS + 100 * N_ELEMS));
        $display("Timeout: the run did not finish within the expected number of cycles");
        abort_run();
    end

endmodule

/* list.f */
expu_pkg.sv
expu_schraudolph.sv
expu_correction.sv
expu_lane.sv
expu_shared_buffer.sv
expu_host_port.sv
expu_top.sv
tb_expu.sv

/* Makefile */
TOP = tb_expu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
